// ==== cr16_pkg.sv ====
// Shared CR16 types, encodings and flag positions, imported by every design unit of the core
package cr16_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [4:0]  flags_t;

    // Major opcode in instruction bits 15:12
    typedef enum logic [3:0] {
        OP_EXT_ALU  = 4'b0000,
        OP_ADDI     = 4'b0001,
        OP_ADDCI    = 4'b0010,
        OP_SUBI     = 4'b0100,
        OP_CMPI     = 4'b0101,
        OP_NOTI     = 4'b0110,
        OP_ANDI     = 4'b0111,
        OP_ORI      = 4'b1000,
        OP_XORI     = 4'b1001,
        OP_MOVIL    = 4'b1010,
        OP_MOVIU    = 4'b1011,
        OP_EXT_MISC = 4'b1111
    } opcode_t;

    // Extension field in bits 7:4 under OP_EXT_ALU
    typedef enum logic [3:0] {
        EXT_ADD  = 4'b0000,
        EXT_ADDC = 4'b0001,
        EXT_SUB  = 4'b0011,
        EXT_CMP  = 4'b0100,
        EXT_NOT  = 4'b0101,
        EXT_AND  = 4'b0110,
        EXT_OR   = 4'b0111,
        EXT_XOR  = 4'b1000,
        EXT_LSH  = 4'b1001,
        EXT_LSHI = 4'b1010,
        EXT_RSH  = 4'b1011,
        EXT_RSHI = 4'b1100
    } ext_t;

    // Same field under OP_EXT_MISC, values overlap the ALU group
    localparam ext_t EXT_MISC_RSHI = ext_t'(4'b0000);
    localparam ext_t EXT_MOV       = ext_t'(4'b0001);
    localparam ext_t EXT_LOAD      = ext_t'(4'b1010);
    localparam ext_t EXT_STORE     = ext_t'(4'b1011);

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDC, ALU_SUB, ALU_NOT, ALU_AND, ALU_OR, ALU_XOR, ALU_LSH, ALU_RSH
    } alu_op_t;

    typedef enum logic [2:0] {
        IC_ALU, IC_CMP, IC_MOV, IC_MOVI, IC_LOAD, IC_STORE, IC_NOP
    } instr_class_t;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXEC_ALU, S_EXEC_MOV,
        S_LOAD_ADDR, S_LOAD_DATA, S_STORE_WRITE, S_STORE_DONE
    } state_t;

    localparam int FLAG_C = 0;
    localparam int FLAG_L = 1;
    localparam int FLAG_F = 2;
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 4;

endpackage

// ==== cr16_dec_if.sv ====
// Decoded instruction fields passed from the decoder to the control unit
`timescale 1ns/1ps

interface cr16_dec_if;
    import cr16_pkg::*;

    word_t        instr;
    instr_class_t iclass;
    alu_op_t      alu_op;
    word_t        imm;
    logic         imm_sel;
    reg_idx_t     rdest;
    reg_idx_t     rsrc;
    word_t        movi_value;

    modport decoder (input instr, output iclass, alu_op, imm, imm_sel, rdest, rsrc, movi_value);
    modport control (output instr, input iclass, alu_op, imm, imm_sel, rdest, rsrc, movi_value);

endinterface

// ==== cr16_dp_if.sv ====
// Select, write-back and operand signals between the control unit and the datapath
`timescale 1ns/1ps

interface cr16_dp_if;
    import cr16_pkg::*;

    // Driven by the control unit
    reg_idx_t a_sel;
    reg_idx_t b_sel;
    logic     reg_we;
    word_t    imm;
    logic     imm_sel;
    alu_op_t  alu_op;
    word_t    wb_data;
    logic     wb_sel;
    // Stored C flag for ADDC
    logic     carry_in;

    // Driven by the datapath
    word_t    a;
    word_t    b;
    flags_t   alu_flags;

    modport control (
        output a_sel, b_sel, reg_we, imm, imm_sel, alu_op, wb_data, wb_sel, carry_in,
        input  a, b, alu_flags
    );
    modport datapath (
        input  a_sel, b_sel, reg_we, imm, imm_sel, alu_op, wb_data, wb_sel, carry_in,
        output a, b, alu_flags
    );

endinterface

// ==== cr16_decoder.sv ====
// Combinational instruction decoder feeding class, ALU operation and immediate to the control unit
`timescale 1ns/1ps

module cr16_decoder (
    cr16_dec_if.decoder dec
);
    import cr16_pkg::*;

    opcode_t    opcode;
    ext_t       ext;
    logic [7:0] imm8;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      imm_shift;

    assign opcode    = opcode_t'(dec.instr[15:12]);
    assign ext       = ext_t'(dec.instr[7:4]);
    assign imm8      = dec.instr[7:0];
    assign imm_sext  = {{8{imm8[7]}}, imm8};
    assign imm_zext  = {8'h00, imm8};
    // Shift amounts only use the Rsrc nibble
    assign imm_shift = {12'h000, dec.instr[3:0]};

    assign dec.rdest      = dec.instr[11:8];
    assign dec.rsrc       = dec.instr[3:0];
    assign dec.movi_value = (opcode == OP_MOVIU) ? {imm8, 8'h00} : imm_zext;

    // Instruction class, anything unlisted falls through as NOP
    always_comb begin
        dec.iclass = IC_NOP;
        case (opcode)
            OP_EXT_ALU: begin
                if (ext == EXT_CMP)
                    dec.iclass = IC_CMP;
                else if (ext inside {EXT_ADD, EXT_ADDC, EXT_SUB, EXT_NOT, EXT_AND, EXT_OR,
                                     EXT_XOR, EXT_LSH, EXT_LSHI, EXT_RSH, EXT_RSHI})
                    dec.iclass = IC_ALU;
            end
            OP_EXT_MISC: begin
                if (ext == EXT_MISC_RSHI)
                    dec.iclass = IC_ALU;
                else if (ext == EXT_MOV)
                    dec.iclass = IC_MOV;
                else if (ext == EXT_LOAD)
                    dec.iclass = IC_LOAD;
                else if (ext == EXT_STORE)
                    dec.iclass = IC_STORE;
            end
            OP_CMPI:
                dec.iclass = IC_CMP;
            OP_ADDI, OP_ADDCI, OP_SUBI, OP_NOTI, OP_ANDI, OP_ORI, OP_XORI:
                dec.iclass = IC_ALU;
            OP_MOVIL, OP_MOVIU:
                dec.iclass = IC_MOVI;
            default:
                dec.iclass = IC_NOP;
        endcase
    end

    // ALU operation, shared by register and immediate forms
    always_comb begin
        dec.alu_op = ALU_ADD;
        if (opcode == OP_EXT_ALU) begin
            case (ext)
                EXT_ADDC:           dec.alu_op = ALU_ADDC;
                EXT_SUB, EXT_CMP:   dec.alu_op = ALU_SUB;
                EXT_NOT:            dec.alu_op = ALU_NOT;
                EXT_AND:            dec.alu_op = ALU_AND;
                EXT_OR:             dec.alu_op = ALU_OR;
                EXT_XOR:            dec.alu_op = ALU_XOR;
                EXT_LSH, EXT_LSHI:  dec.alu_op = ALU_LSH;
                EXT_RSH, EXT_RSHI:  dec.alu_op = ALU_RSH;
                default:            dec.alu_op = ALU_ADD;
            endcase
        end else if (opcode == OP_EXT_MISC) begin
            // Only RSHI reaches the ALU from this group
            dec.alu_op = ALU_RSH;
        end else begin
            case (opcode)
                OP_ADDCI:          dec.alu_op = ALU_ADDC;
                OP_SUBI, OP_CMPI:  dec.alu_op = ALU_SUB;
                OP_NOTI:           dec.alu_op = ALU_NOT;
                OP_ANDI:           dec.alu_op = ALU_AND;
                OP_ORI:            dec.alu_op = ALU_OR;
                OP_XORI:           dec.alu_op = ALU_XOR;
                default:           dec.alu_op = ALU_ADD;
            endcase
        end
    end

    // Immediate extension and operand select
    always_comb begin
        dec.imm     = imm_zext;
        dec.imm_sel = 1'b1;
        case (opcode)
            OP_ADDI, OP_ADDCI, OP_SUBI, OP_CMPI:
                dec.imm = imm_sext;
            OP_NOTI, OP_ANDI, OP_ORI, OP_XORI:
                dec.imm = imm_zext;
            OP_EXT_ALU: begin
                dec.imm     = imm_shift;
                dec.imm_sel = (ext == EXT_LSHI) || (ext == EXT_RSHI);
            end
            OP_EXT_MISC: begin
                dec.imm     = imm_shift;
                dec.imm_sel = (ext == EXT_MISC_RSHI);
            end
            default:
                dec.imm_sel = 1'b0;
        endcase
    end

    // A known word must always resolve to some class, NOP included
    always_comb begin
        if (!$isunknown(dec.instr))
            assert final (!$isunknown(dec.iclass))
                else $error("decoder: iclass unknown for instr %h", dec.instr);
    end

endmodule

// ==== cr16_regfile.sv ====
// Register file of the core, two combinational read ports and one clocked write port
`timescale 1ns/1ps

module cr16_regfile #(
    parameter int NUM_REGS = 16
) (
    input  logic              I_CLK,
    input  logic              I_NRESET,
    input  logic              we,
    input  cr16_pkg::reg_idx_t waddr,
    input  cr16_pkg::word_t   wdata,
    input  cr16_pkg::reg_idx_t raddr_a,
    input  cr16_pkg::reg_idx_t raddr_b,
    output cr16_pkg::word_t   rdata_a,
    output cr16_pkg::word_t   rdata_b
);
    import cr16_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && (int'(waddr) < NUM_REGS)) begin
            regs[waddr] <= wdata;
        end
    end

    // Indices past NUM_REGS read as zero
    assign rdata_a = (int'(raddr_a) < NUM_REGS) ? regs[raddr_a] : '0;
    assign rdata_b = (int'(raddr_b) < NUM_REGS) ? regs[raddr_b] : '0;

    // Write data comes through the datapath mux from the control unit or ALU
    assert property (@(posedge I_CLK) disable iff (!I_NRESET) we |-> !$isunknown(wdata))
        else $error("regfile: unknown write data to r%0d", waddr);

endmodule

// ==== cr16_alu.sv ====
// ALU of the datapath, computes the result and the five status flags for one operation
`timescale 1ns/1ps

module cr16_alu (
    input  cr16_pkg::alu_op_t op,
    input  cr16_pkg::word_t   src,
    input  cr16_pkg::word_t   dst,
    input  logic              carry_in,
    output cr16_pkg::word_t   result,
    output cr16_pkg::flags_t  flags
);
    import cr16_pkg::*;

    logic [16:0] sum;
    logic [16:0] diff;
    logic        add_ovf;
    logic        sub_ovf;

    // Carry only enters for ADDC
    assign sum  = {1'b0, dst} + {1'b0, src} + {16'h0000, (op == ALU_ADDC) & carry_in};
    assign diff = {1'b0, dst} - {1'b0, src};

    // Same-sign operands with a sum of the other sign
    assign add_ovf = (dst[15] == src[15]) && (sum[15] != dst[15]);
    // Opposite-sign operands where the difference loses the sign of dst
    assign sub_ovf = (dst[15] != src[15]) && (diff[15] != dst[15]);

    always_comb begin
        case (op)
            ALU_ADD, ALU_ADDC: result = sum[15:0];
            ALU_SUB:           result = diff[15:0];
            ALU_NOT:           result = ~src;
            ALU_AND:           result = dst & src;
            ALU_OR:            result = dst | src;
            ALU_XOR:           result = dst ^ src;
            ALU_LSH:           result = dst << src[3:0];
            ALU_RSH:           result = dst >> src[3:0];
            default:           result = '0;
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[FLAG_Z] = (result == '0);
        flags[FLAG_N] = result[15];
        case (op)
            ALU_ADD, ALU_ADDC: begin
                flags[FLAG_C] = sum[16];
                flags[FLAG_F] = add_ovf;
            end
            ALU_SUB: begin
                flags[FLAG_N] = $signed(dst) < $signed(src);
                // Borrow out doubles as the unsigned less-than
                flags[FLAG_C] = diff[16];
                flags[FLAG_L] = diff[16];
                flags[FLAG_F] = sub_ovf;
            end
            default: ;
        endcase
    end

endmodule

// ==== cr16_datapath.sv ====
// Datapath of the core, register file and ALU with operand and write-back muxing
`timescale 1ns/1ps

module cr16_datapath #(
    parameter int NUM_REGS = 16
) (
    input  logic         I_CLK,
    input  logic         I_NRESET,
    input  logic         enable,
    cr16_dp_if.datapath  dp
);
    import cr16_pkg::*;

    word_t alu_src;
    word_t alu_result;
    word_t wdata;

    // Immediate replaces Rsrc on the ALU source side
    assign alu_src = dp.imm_sel ? dp.imm : dp.a;
    assign wdata   = dp.wb_sel ? dp.wb_data : alu_result;

    // Rdest is both the second operand and the write target
    cr16_regfile #(
        .NUM_REGS (NUM_REGS)
    ) regfile_i (
        .I_CLK    (I_CLK),
        .I_NRESET (I_NRESET),
        .we       (dp.reg_we & enable),
        .waddr    (dp.b_sel),
        .wdata    (wdata),
        .raddr_a  (dp.a_sel),
        .raddr_b  (dp.b_sel),
        .rdata_a  (dp.a),
        .rdata_b  (dp.b)
    );

    cr16_alu alu_i (
        .op       (dp.alu_op),
        .src      (alu_src),
        .dst      (dp.b),
        .carry_in (dp.carry_in),
        .result   (alu_result),
        .flags    (dp.alu_flags)
    );

endmodule

// ==== cr16_control.sv ====
// Control unit of the core, FSM with program counter, instruction and flag registers and memory port
`timescale 1ns/1ps

module cr16_control (
    input  logic              I_CLK,
    input  logic              I_NRESET,
    input  logic              enable,
    input  cr16_pkg::word_t   mem_rdata,
    output cr16_pkg::word_t   mem_addr,
    output cr16_pkg::word_t   mem_wdata,
    output logic              mem_we,
    output cr16_pkg::flags_t  status_flags,
    output cr16_pkg::word_t   pc,
    cr16_dec_if.control       dec,
    cr16_dp_if.control        dp
);
    import cr16_pkg::*;

    state_t state;
    state_t next_state;
    logic   mem_we_q;

    // Strobe is held low during stalls
    assign mem_we      = mem_we_q & enable;
    assign dp.carry_in = status_flags[FLAG_C];

    always_comb begin
        case (state)
            S_FETCH:       next_state = S_DECODE;
            S_DECODE: begin
                case (dec.iclass)
                    IC_ALU, IC_CMP:  next_state = S_EXEC_ALU;
                    IC_MOV, IC_MOVI: next_state = S_EXEC_MOV;
                    IC_LOAD:         next_state = S_LOAD_ADDR;
                    IC_STORE:        next_state = S_STORE_WRITE;
                    default:         next_state = S_FETCH;
                endcase
            end
            S_LOAD_ADDR:   next_state = S_LOAD_DATA;
            S_STORE_WRITE: next_state = S_STORE_DONE;
            default:       next_state = S_FETCH;
        endcase
    end

    // Register write-back, enable gating is done in the datapath
    always_comb begin
        dp.reg_we  = 1'b0;
        dp.wb_sel  = 1'b0;
        dp.wb_data = mem_rdata;
        case (state)
            S_EXEC_ALU:
                dp.reg_we = (dec.iclass != IC_CMP);
            S_EXEC_MOV: begin
                dp.reg_we  = 1'b1;
                dp.wb_sel  = 1'b1;
                dp.wb_data = (dec.iclass == IC_MOVI) ? dec.movi_value : dp.a;
            end
            S_LOAD_DATA: begin
                dp.reg_we = 1'b1;
                dp.wb_sel = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            state        <= S_FETCH;
            dec.instr    <= '0;
            pc           <= '0;
            status_flags <= '0;
            mem_addr     <= '0;
            mem_wdata    <= '0;
            mem_we_q     <= 1'b0;
            dp.a_sel     <= '0;
            dp.b_sel     <= '0;
            dp.imm       <= '0;
            dp.imm_sel   <= 1'b0;
            dp.alu_op    <= ALU_ADD;
        end else if (enable) begin
            state <= next_state;
            case (state)
                S_FETCH: begin
                    dec.instr <= mem_rdata;
                    pc        <= pc + 16'd1;
                end
                S_DECODE: begin
                    // Point memory at the next instruction early
                    mem_addr   <= pc;
                    dp.a_sel   <= dec.rsrc;
                    dp.b_sel   <= dec.rdest;
                    dp.imm     <= dec.imm;
                    dp.imm_sel <= dec.imm_sel;
                    dp.alu_op  <= dec.alu_op;
                end
                S_EXEC_ALU:
                    status_flags <= dp.alu_flags;
                S_LOAD_ADDR:
                    mem_addr <= dp.a;
                S_LOAD_DATA:
                    mem_addr <= pc;
                S_STORE_WRITE: begin
                    mem_addr  <= dp.b;
                    mem_wdata <= dp.a;
                    mem_we_q  <= 1'b1;
                end
                S_STORE_DONE: begin
                    mem_we_q <= 1'b0;
                    mem_addr <= pc;
                end
                default: ;
            endcase
        end
    end

    // Strobe is raised by STORE_WRITE and dropped when STORE_DONE advances
    assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_we_q |-> (state == S_STORE_DONE) &&
                     ($past(state) inside {S_STORE_WRITE, S_STORE_DONE}))
        else $error("control: mem_we outside a store sequence");

    assert property (@(posedge I_CLK) disable iff (!I_NRESET) !$isunknown(state))
        else $error("control: state left the encoding");

endmodule

// ==== cr16_top.sv ====
// Top level of the CR16 core, connects control, decoder and datapath to the memory port
`timescale 1ns/1ps

module cr16_top #(
    parameter int NUM_REGS = 16
) (
    input  logic              I_CLK,
    input  logic              I_NRESET,
    input  logic              enable,
    input  cr16_pkg::word_t   mem_rdata,
    output cr16_pkg::word_t   mem_addr,
    output cr16_pkg::word_t   mem_wdata,
    output logic              mem_we,
    output cr16_pkg::flags_t  status_flags,
    output cr16_pkg::word_t   pc
);

    cr16_dec_if dec_if_i ();
    cr16_dp_if  dp_if_i ();

    cr16_control control_i (
        .I_CLK        (I_CLK),
        .I_NRESET     (I_NRESET),
        .enable       (enable),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .status_flags (status_flags),
        .pc           (pc),
        .dec          (dec_if_i.control),
        .dp           (dp_if_i.control)
    );

    cr16_decoder decoder_i (
        .dec (dec_if_i.decoder)
    );

    cr16_datapath #(
        .NUM_REGS (NUM_REGS)
    ) datapath_i (
        .I_CLK    (I_CLK),
        .I_NRESET (I_NRESET),
        .enable   (enable),
        .dp       (dp_if_i.datapath)
    );

endmodule

// ==== tb_cr16_model.svh ====
// Instruction-level reference model and random program generator, included inside tb_cr16
`ifndef TB_CR16_MODEL_SVH
`define TB_CR16_MODEL_SVH

logic [31:0] rand_state;
word_t       model_regs [16];
flags_t      model_flags;
word_t       model_pc;
word_t       model_mem [0:65535];

// Store issued by the model and not yet seen on the memory port
bit          store_pending;
word_t       store_addr;
word_t       store_data;

// 32-bit xorshift generator
function automatic logic [31:0] next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
endfunction

// One ALU operation, dst is the Rdest value and src the register or immediate operand
task automatic apply_alu(input alu_op_t op, input word_t dst, input word_t src,
                         output word_t res, output flags_t fl);
    logic [16:0] wide;
    int          exact;
    int          cin;
    fl  = '0;
    cin = (op == ALU_ADDC) ? int'(model_flags[FLAG_C]) : 0;
    case (op)
        ALU_ADD, ALU_ADDC: begin
            wide       = {1'b0, dst} + {1'b0, src} + 17'(cin);
            exact      = int'($signed(dst)) + int'($signed(src)) + cin;
            res        = wide[15:0];
            fl[FLAG_C] = wide[16];
            fl[FLAG_F] = (exact > 32767) || (exact < -32768);
        end
        ALU_SUB: begin
            exact      = int'($signed(dst)) - int'($signed(src));
            res        = dst - src;
            fl[FLAG_C] = (src > dst);
            fl[FLAG_L] = (dst < src);
            fl[FLAG_F] = (exact > 32767) || (exact < -32768);
        end
        ALU_NOT: res = ~src;
        ALU_AND: res = dst & src;
        ALU_OR:  res = dst | src;
        ALU_XOR: res = dst ^ src;
        ALU_LSH: res = dst << src[3:0];
        ALU_RSH: res = dst >> src[3:0];
        default: res = '0;
    endcase
    fl[FLAG_Z] = (res == 16'h0000);
    // Signed less-than for compares, sign of the result otherwise
    fl[FLAG_N] = (op == ALU_SUB) ? (int'($signed(dst)) < int'($signed(src))) : res[15];
endtask

task automatic run_alu(input alu_op_t op, input logic [3:0] rd, input word_t src,
                       input bit write_back);
    word_t  res;
    flags_t fl;
    apply_alu(op, model_regs[rd], src, res, fl);
    model_flags = fl;
    if (write_back)
        model_regs[rd] = res;
endtask

// Executes the instruction at model_pc, unknown encodings do nothing
task automatic model_step();
    word_t      w;
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] ext;
    word_t      rs_val;
    word_t      imm_s;
    word_t      imm_z;
    word_t      shamt;
    w        = model_mem[model_pc];
    model_pc = model_pc + 16'd1;
    op       = w[15:12];
    rd       = w[11:8];
    ext      = w[7:4];
    rs_val   = model_regs[w[3:0]];
    imm_s    = {{8{w[7]}}, w[7:0]};
    imm_z    = {8'h00, w[7:0]};
    shamt    = {12'h000, w[3:0]};
    case (op)
        OP_EXT_ALU: begin
            case (ext)
                EXT_ADD:  run_alu(ALU_ADD, rd, rs_val, 1'b1);
                EXT_ADDC: run_alu(ALU_ADDC, rd, rs_val, 1'b1);
                EXT_SUB:  run_alu(ALU_SUB, rd, rs_val, 1'b1);
                EXT_CMP:  run_alu(ALU_SUB, rd, rs_val, 1'b0);
                EXT_NOT:  run_alu(ALU_NOT, rd, rs_val, 1'b1);
                EXT_AND:  run_alu(ALU_AND, rd, rs_val, 1'b1);
                EXT_OR:   run_alu(ALU_OR, rd, rs_val, 1'b1);
                EXT_XOR:  run_alu(ALU_XOR, rd, rs_val, 1'b1);
                EXT_LSH:  run_alu(ALU_LSH, rd, rs_val, 1'b1);
                EXT_RSH:  run_alu(ALU_RSH, rd, rs_val, 1'b1);
                EXT_LSHI: run_alu(ALU_LSH, rd, shamt, 1'b1);
                EXT_RSHI: run_alu(ALU_RSH, rd, shamt, 1'b1);
                default:  ;
            endcase
        end
        OP_EXT_MISC: begin
            case (ext)
                EXT_MISC_RSHI: run_alu(ALU_RSH, rd, shamt, 1'b1);
                EXT_MOV:       model_regs[rd] = rs_val;
                EXT_LOAD:      model_regs[rd] = model_mem[rs_val];
                EXT_STORE: begin
                    store_addr            = model_regs[rd];
                    store_data            = rs_val;
                    model_mem[store_addr] = store_data;
                    store_pending         = 1'b1;
                end
                default: ;
            endcase
        end
        OP_ADDI:  run_alu(ALU_ADD, rd, imm_s, 1'b1);
        OP_ADDCI: run_alu(ALU_ADDC, rd, imm_s, 1'b1);
        OP_SUBI:  run_alu(ALU_SUB, rd, imm_s, 1'b1);
        OP_CMPI:  run_alu(ALU_SUB, rd, imm_s, 1'b0);
        OP_NOTI:  run_alu(ALU_NOT, rd, imm_z, 1'b1);
        OP_ANDI:  run_alu(ALU_AND, rd, imm_z, 1'b1);
        OP_ORI:   run_alu(ALU_OR, rd, imm_z, 1'b1);
        OP_XORI:  run_alu(ALU_XOR, rd, imm_z, 1'b1);
        OP_MOVIL: model_regs[rd] = imm_z;
        OP_MOVIU: model_regs[rd] = {w[7:0], 8'h00};
        default:  ;
    endcase
endtask

// Mostly supported instructions, one in ten a raw random word
function automatic word_t random_instruction();
    logic [3:0]  reg_exts [10] = '{EXT_ADD, EXT_ADDC, EXT_SUB, EXT_CMP, EXT_NOT,
                                   EXT_AND, EXT_OR, EXT_XOR, EXT_LSH, EXT_RSH};
    logic [3:0]  imm_ops [8]   = '{OP_ADDI, OP_ADDCI, OP_SUBI, OP_CMPI,
                                   OP_NOTI, OP_ANDI, OP_ORI, OP_XORI};
    logic [31:0] r;
    logic [31:0] sel;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [7:0]  imm8;
    int          form;
    r    = next_random();
    sel  = next_random();
    rd   = r[3:0];
    rs   = r[7:4];
    imm8 = r[15:8];
    form = int'((sel >> 4) % 26);
    if (sel % 10 == 0)
        return r[31:16];
    if (form < 10)
        return {OP_EXT_ALU, rd, reg_exts[form], rs};
    if (form < 18)
        return {imm_ops[form - 10], rd, imm8};
    case (form)
        18:      return {OP_EXT_ALU, rd, EXT_LSHI, rs};
        19:      return {OP_EXT_ALU, rd, EXT_RSHI, rs};
        20:      return {OP_EXT_MISC, rd, EXT_MISC_RSHI, rs};
        21:      return {OP_EXT_MISC, rd, EXT_MOV, rs};
        22:      return {OP_MOVIL, rd, imm8};
        23:      return {OP_MOVIU, rd, imm8};
        24:      return {OP_EXT_MISC, rd, EXT_LOAD, rs};
        default: return {OP_EXT_MISC, rd, EXT_STORE, rs};
    endcase
endfunction

`endif

// ==== tb_cr16.sv ====
// Testbench for cr16_top, runs a random program against the reference model and checks the core
`timescale 1ns/1ps

module tb_cr16;
    import cr16_pkg::*;

    localparam int NUM_INSTR      = 300;
    localparam int PROGRAM_WORDS  = 128;
    localparam int TIMEOUT_CYCLES = 20;

    logic   I_CLK;
    logic   I_NRESET;
    logic   enable;
    word_t  mem_rdata;
    word_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_we;
    flags_t status_flags;
    word_t  pc;

    logic [15:0] mem [0:65535];
    int          mismatch_count;
    int          failure_count;
    bit          run_active;
    word_t       last_pc;
    word_t       prev_pc;
    logic        prev_enable;
    logic        prev_mem_we;

    `include "tb_cr16_model.svh"

    cr16_top #(
        .NUM_REGS (16)
    ) dut_i (
        .I_CLK        (I_CLK),
        .I_NRESET     (I_NRESET),
        .enable       (enable),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .status_flags (status_flags),
        .pc           (pc)
    );

    initial I_CLK = 1'b0;
    always #10 I_CLK = ~I_CLK;

    // Combinational read, write on the rising edge
    assign mem_rdata = mem[mem_addr];
    always @(posedge I_CLK) begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
    end

    // Stall input, high about four cycles in five once the run starts
    always @(posedge I_CLK) begin
        #2;
        if (run_active)
            enable = ((next_random() % 10) < 8);
    end

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < 65536; a++) begin
            mem[a]       = '0;
            model_mem[a] = '0;
        end
        for (int i = 0; i < PROGRAM_WORDS; i++) begin
            model_mem[i] = random_instruction();
            mem[i]       = model_mem[i];
        end
        for (int r = 0; r < 16; r++)
            model_regs[r] = '0;
        model_flags   = '0;
        model_pc      = '0;
        store_pending = 1'b0;
    endtask

    // Stall behavior and store strobes, sampled mid-cycle
    task automatic check_cycle();
        if (!prev_enable)
            check_word("pc during stall", pc, prev_pc);
        if (!enable && !prev_mem_we)
            assert (!mem_we) else begin
                failure_count++;
                $display("mem_we rose while enable was low at %0t", $time);
            end
        if (mem_we) begin
            assert (store_pending) else begin
                failure_count++;
                $display("write strobe with no store pending in the model at %0t", $time);
            end
            if (store_pending) begin
                check_word("mem_addr", mem_addr, store_addr);
                check_word("mem_wdata", mem_wdata, store_data);
                store_pending = 1'b0;
            end
        end
        prev_pc     = pc;
        prev_enable = enable;
        prev_mem_we = mem_we;
    endtask

    task automatic wait_pc_change(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(negedge I_CLK);
            cycles++;
            check_cycle();
            if (pc !== last_pc)
                ok = 1'b1;
        end
        assert (ok) else begin
            failure_count++;
            $display("timeout: pc stayed at %h for %0d cycles", last_pc, TIMEOUT_CYCLES);
        end
    endtask

    task automatic compare_memory();
        for (int a = 0; a < 65536; a++) begin
            assert (mem[a] === model_mem[a]) else begin
                mismatch_count++;
                $display("mismatch mem[%h]: got %h, expected %h", a[15:0], mem[a],
                         model_mem[a]);
            end
        end
    endtask

    initial begin
        bit ok;
        I_NRESET       = 1'b0;
        enable         = 1'b0;
        run_active     = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        rand_state     = 32'd14;
        load_program();
        repeat (5) @(posedge I_CLK);
        #2 I_NRESET = 1'b1;

        // Reset values while enable is still low
        repeat (2) begin
            @(negedge I_CLK);
            check_word("pc", pc, 16'h0000);
            check_word("mem_addr", mem_addr, 16'h0000);
            check_word("status_flags", {11'h000, status_flags}, 16'h0000);
            check_word("mem_we", {15'h0000, mem_we}, 16'h0000);
        end
        last_pc     = pc;
        prev_pc     = pc;
        prev_enable = enable;
        prev_mem_we = mem_we;
        run_active  = 1'b1;

        // One extra fetch closes out the last instruction
        ok = 1'b1;
        for (int k = 1; k <= NUM_INSTR + 1 && ok; k++) begin
            wait_pc_change(ok);
            if (ok) begin
                check_word("status_flags", {11'h000, status_flags}, {11'h000, model_flags});
                check_word("pc step", pc, last_pc + 16'd1);
                assert (!store_pending) else begin
                    failure_count++;
                    $display("store at %h never appeared on the memory port", store_addr);
                    store_pending = 1'b0;
                end
                if (k <= NUM_INSTR) begin
                    model_step();
                    check_word("pc", pc, model_pc);
                end
                last_pc = pc;
            end
        end
        if (ok)
            compare_memory();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== cr16.f ====
+incdir+.
cr16_pkg.sv
cr16_dec_if.sv
cr16_dp_if.sv
cr16_decoder.sv
cr16_regfile.sv
cr16_alu.sv
cr16_datapath.sv
cr16_control.sv
cr16_top.sv
tb_cr16.sv

// ==== Bender.yml ====
package:
  name: cr16

sources:
  - cr16_pkg.sv
  - cr16_dec_if.sv
  - cr16_dp_if.sv
  - cr16_decoder.sv
  - cr16_regfile.sv
  - cr16_alu.sv
  - cr16_datapath.sv
  - cr16_control.sv
  - cr16_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cr16.sv
